/* Bender.yml */
package:
  name: gps_track

sources:
  - src/gps_track_pkg.sv
  - src/sample_sync.sv
  - src/init_fifo.sv
  - src/ca_code_gen.sv
  - src/correlator_channel.sv
  - src/track_mem_arbiter.sv
  - src/code_tracker.sv
  - src/gps_track_top.sv
  - target: simulation
    files:
      - sim/tb_gps_track.sv

/* sim/tb_gps_track.sv */
`timescale 1ns/1ps

module tb_gps_track;
   import gps_track_pkg::*;

   typedef struct packed {
      int prn;
      int shift;
      int rnd;      // 0 gives prompt-matched +3/-3, 1 gives random samples.
      int periods;
      int extra;    // Acquisition pushes after the first one.
   } case_t;

   logic              clk;
   logic              i_rst_n;
   logic              i_clk_sample;
   sample_t           i_data;
   logic              i_acq_valid;
   prn_t              i_acq_prn;
   code_shift_t       i_acq_code_shift;
   logic              o_acq_full;
   logic              o_trk_valid;
   prn_t              o_trk_prn;
   acc_t              o_prompt_mag;
   logic signed [8:0] o_code_err;

   int   errors;
   logic ca [CA_LEN];
   int   smp [$];
   int   exp_mag [$];
   int   exp_err [$];

   gps_track_top uut (
      .clk              (clk),
      .i_rst_n          (i_rst_n),
      .i_clk_sample     (i_clk_sample),
      .i_data           (i_data),
      .i_acq_valid      (i_acq_valid),
      .i_acq_prn        (i_acq_prn),
      .i_acq_code_shift (i_acq_code_shift),
      .o_acq_full       (o_acq_full),
      .o_trk_valid      (o_trk_valid),
      .o_trk_prn        (o_trk_prn),
      .o_prompt_mag     (o_prompt_mag),
      .o_code_err       (o_code_err)
   );

   always #2 clk = ~clk;

   ////////////////////
   // Case table
   ////////////////////

   // A zero period count ends the table.
   function automatic case_t case_entry(int idx);
      case (idx)
         0: return '{1, 0, 0, 1, 0};
         1: return '{7, 0, 0, 1, 0};
         2: return '{32, 0, 0, 1, 0};
         3: return '{7, 300, 0, 2, 0};
         4: return '{19, 517, 1, 4, 0};
         5: return '{3, 12, 1, 1, 1};
         6: return '{24, 5, 1, 1, 5};
         default: return '{0, 0, 0, 0, 0};
      endcase
   endfunction

   ////////////////////
   // Reference model
   ////////////////////

   // Stage 1 takes the feedback, stage 10 feeds the output.
   function automatic void build_code(int prn);
      logic [1:10] g1;
      logic [1:10] g2;
      int          ta;
      int          tb;
      logic        fb1;
      logic        fb2;
      g1 = '1;
      g2 = '1;
      ta = G2_TAP_A[prn];
      tb = G2_TAP_B[prn];
      for (int i = 0; i < CA_LEN; i++) begin
         ca[i] = g1[10] ^ g2[ta] ^ g2[tb];
         fb1 = g1[3] ^ g1[10];
         fb2 = g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10];
         g1 = {fb1, g1[1:9]};
         g2 = {fb2, g2[1:9]};
      end
   endfunction

   // Lag 0 early, 1 prompt, 2 late. History starts out as zero chips.
   function automatic logic chip_at(int shift, int k, int lag);
      return (k < lag) ? 1'b0 : ca[(shift + k - lag) % CA_LEN];
   endfunction

   function automatic int accumulate(int acc, int v, logic chip);
      int s;
      s = chip ? acc + v : acc - v;
      if (s > ACC_MAX) begin
         s = ACC_MAX;
      end else if (s < ACC_MIN) begin
         s = ACC_MIN;
      end
      return s;
   endfunction

   function automatic int abs_int(int v);
      return (v < 0) ? -v : v;
   endfunction

   task automatic check_val(string name, logic [31:0] exp_v, logic [31:0] act_v);
      if (exp_v !== act_v) begin
         errors++;
         $display("Fail %s: expected %h, got %h", name, exp_v, act_v);
      end
   endtask

   task automatic prepare_case(case_t c);
      int e;
      int p;
      int l;
      int v;
      build_code(c.prn);
      smp.delete();
      exp_mag.delete();
      exp_err.delete();
      e = 0;
      p = 0;
      l = 0;
      for (int k = 0; k < c.periods * ACC_LEN; k++) begin
         if (c.rnd != 0) begin
            v = $urandom % 8;
            if (v > 3) begin
               v = v - 8;
            end
         end else begin
            v = chip_at(c.shift, k, 1) ? 3 : -3;
         end
         smp.push_back(v);
         e = accumulate(e, v, chip_at(c.shift, k, 0));
         p = accumulate(p, v, chip_at(c.shift, k, 1));
         l = accumulate(l, v, chip_at(c.shift, k, 2));
         if (k % ACC_LEN == ACC_LEN - 1) begin
            exp_mag.push_back(abs_int(p));
            exp_err.push_back(abs_int(e) - abs_int(l));
            e = 0;
            p = 0;
            l = 0;
         end
      end
   endtask

   ////////////////////
   // Stimulus
   ////////////////////

   task automatic apply_reset();
      @(posedge clk);
      i_rst_n      <= 1'b0;
      i_acq_valid  <= 1'b0;
      i_clk_sample <= 1'b0;
      repeat (4) begin
         @(posedge clk);
         @(negedge clk);
         check_val("o_trk_valid", 0, o_trk_valid);
         check_val("o_acq_full", 0, o_acq_full);
      end
      @(posedge clk);
      i_rst_n <= 1'b1;
      repeat (2) begin
         @(negedge clk);
         check_val("o_trk_valid", 0, o_trk_valid);
         check_val("o_acq_full", 0, o_acq_full);
      end
   endtask

   // Sample clock toggles every 4 clk cycles, data changes on its rising edge.
   task automatic drive_samples();
      @(posedge clk);
      foreach (smp[k]) begin
         i_clk_sample <= 1'b1;
         i_data       <= sample_t'(smp[k]);
         repeat (4) @(posedge clk);
         i_clk_sample <= 1'b0;
         repeat (4) @(posedge clk);
      end
   endtask

   task automatic collect_reports(case_t c);
      for (int n = 0; n < c.periods; n++) begin
         @(negedge clk);
         while (!o_trk_valid) @(negedge clk);
         check_val("o_trk_prn", c.prn, o_trk_prn);
         check_val("o_prompt_mag", exp_mag[n], o_prompt_mag);
         check_val("o_code_err", exp_err[n], o_code_err);
      end
   endtask

   task automatic run_case(case_t c);
      apply_reset();
      prepare_case(c);
      @(posedge clk);
      i_acq_valid      <= 1'b1;
      i_acq_prn        <= prn_t'(c.prn);
      i_acq_code_shift <= code_shift_t'(c.shift);
      // Later pushes carry another PRN and must not be the one tracked.
      for (int j = 0; j < c.extra; j++) begin
         @(posedge clk);
         i_acq_prn        <= prn_t'(c.prn % 32 + 1);
         i_acq_code_shift <= code_shift_t'(j + 1);
      end
      @(posedge clk);
      i_acq_valid <= 1'b0;
      @(negedge clk);
      check_val("o_acq_full", c.extra >= INIT_DEPTH, o_acq_full);
      // Seek steps one chip per clock.
      repeat (c.shift + 8) @(posedge clk);
      fork
         drive_samples();
         collect_reports(c);
      join
   endtask

   initial begin
      case_t c;
      int    idx;
      clk              = 1'b0;
      i_rst_n          = 1'b0;
      i_clk_sample     = 1'b0;
      i_data           = '0;
      i_acq_valid      = 1'b0;
      i_acq_prn        = '0;
      i_acq_code_shift = '0;
      errors           = 0;
      idx = $urandom(32'h697365c8);
      idx = 0;
      c   = case_entry(0);
      while (c.periods > 0) begin
         run_case(c);
         idx++;
         c = case_entry(idx);
      end
      $display("Checks done with %0d errors", errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // Watchdog sized from the total number of accumulation periods.
   initial begin
      case_t c;
      int    idx;
      int    total;
      total = 0;
      idx   = 0;
      c     = case_entry(0);
      while (c.periods > 0) begin
         total += c.periods;
         idx++;
         c = case_entry(idx);
      end
      repeat (total * ACC_LEN * 8 + 2000) @(posedge clk);
      $display("Run timed out after %0d clock cycles with %0d errors",
               total * ACC_LEN * 8 + 2000, errors);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

/* src/ca_code_gen.sv */
`timescale 1ns/1ps

module ca_code_gen (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic                       i_load,
   input  gps_track_pkg::prn_t        i_prn,
   input  gps_track_pkg::code_shift_t i_seek_shift,
   input  logic                       i_advance,
   output logic                       o_chip,
   output logic                       o_seek_done
);
   import gps_track_pkg::*;

   // Stage 1 takes the feedback; stage 10 is the output end.
   logic [10:1] g1;
   logic [10:1] g2;
   logic [3:0]  tap_a;
   logic [3:0]  tap_b;
   code_shift_t seek_cnt;
   logic        step;

   assign o_seek_done = (seek_cnt == '0);
   assign step        = !o_seek_done || i_advance;
   assign o_chip      = g1[10] ^ g2[tap_a] ^ g2[tap_b];

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         g1       <= '1;
         g2       <= '1;
         seek_cnt <= '0;
      end else if (i_load) begin
         g1 <= '1;
         g2 <= '1;
         // A full code period is the same phase as zero.
         seek_cnt <= (i_seek_shift >= CA_LEN) ? '0 : i_seek_shift;
      end else begin
         if (!o_seek_done) begin
            seek_cnt <= seek_cnt - 1'b1;
         end
         if (step) begin
            g1 <= {g1[9:1], g1[3] ^ g1[10]};
            g2 <= {g2[9:1], g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]};
         end
      end
   end

   ////////////////////
   // PRN tap select
   ////////////////////

   always_ff @(posedge clk) begin
      if (i_load) begin
         tap_a <= G2_TAP_A[i_prn];
         tap_b <= G2_TAP_B[i_prn];
      end
   end

endmodule

/* src/code_tracker.sv */
`timescale 1ns/1ps

module code_tracker (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  logic                     i_dump,
   input  gps_track_pkg::mem_addr_t i_dump_addr,
   output logic                     o_rd_req,
   output gps_track_pkg::mem_addr_t o_rd_addr,
   input  logic                     i_rd_ack,
   input  gps_track_pkg::mem_word_t i_rd_data,
   output logic                     o_trk_valid,
   output gps_track_pkg::prn_t      o_trk_prn,
   output gps_track_pkg::acc_t      o_prompt_mag,
   output logic signed [8:0]        o_code_err
);
   import gps_track_pkg::*;

   logic                  idle;
   logic                  pend;
   mem_addr_t             pend_addr;
   logic signed [ACC_W:0] e_abs;
   logic signed [ACC_W:0] p_abs;
   logic signed [ACC_W:0] l_abs;

   function automatic logic signed [ACC_W:0] abs_acc(acc_t v);
      logic signed [ACC_W:0] wide;
      wide = v;
      return (wide < 0) ? -wide : wide;
   endfunction

   assign idle  = !o_rd_req && !i_rd_ack;
   assign e_abs = abs_acc(i_rd_data[3*ACC_W-1:2*ACC_W]);
   assign p_abs = abs_acc(i_rd_data[2*ACC_W-1:ACC_W]);
   assign l_abs = abs_acc(i_rd_data[ACC_W-1:0]);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_rd_req    <= 1'b0;
         o_trk_valid <= 1'b0;
         pend        <= 1'b0;
      end else begin
         o_trk_valid <= 1'b0;
         if (o_rd_req && i_rd_ack) begin
            o_rd_req    <= 1'b0;
            o_trk_valid <= 1'b1;
         end else if (idle && pend) begin
            o_rd_req  <= 1'b1;
            o_rd_addr <= pend_addr;
            pend      <= 1'b0;
         end else if (idle && i_dump) begin
            o_rd_req  <= 1'b1;
            o_rd_addr <= i_dump_addr;
         end
         // Dump that cannot start now waits for the next free slot.
         if (i_dump && !(idle && !pend)) begin
            pend      <= 1'b1;
            pend_addr <= i_dump_addr;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (o_rd_req && i_rd_ack) begin
         o_trk_prn    <= i_rd_data[WORD_W-1 -: PRN_W];
         o_prompt_mag <= (p_abs > ACC_MAX) ? acc_t'(ACC_MAX) : acc_t'(p_abs);
         o_code_err   <= e_abs - l_abs;
      end
   end

endmodule

/* src/correlator_channel.sv */
`timescale 1ns/1ps

module correlator_channel (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic                       i_sample_valid,
   input  gps_track_pkg::sample_t     i_sample,
   input  logic                       i_init_empty,
   input  gps_track_pkg::prn_t        i_init_prn,
   input  gps_track_pkg::code_shift_t i_init_shift,
   output logic                       o_init_pop,
   output logic                       o_wr_req,
   output gps_track_pkg::mem_addr_t   o_wr_addr,
   output gps_track_pkg::mem_word_t   o_wr_data,
   input  logic                       i_wr_ack,
   output logic                       o_dump,
   output gps_track_pkg::mem_addr_t   o_dump_addr
);
   import gps_track_pkg::*;

   chan_state_e          state;
   logic                 chip;
   logic                 seek_done;
   logic                 take;
   logic [1:0]           hist;  // [0] prompt chip, [1] late chip.
   prn_t                 prn_q;
   acc_t                 acc_e;
   acc_t                 acc_p;
   acc_t                 acc_l;
   logic [ACC_CNT_W-1:0] smp_cnt;
   mem_addr_t            wr_addr;

   function automatic acc_t sat_acc(acc_t acc, sample_t s, logic c);
      logic signed [ACC_W:0] sum;
      sum = acc;
      sum = c ? sum + s : sum - s;
      if (sum > ACC_MAX) begin
         return acc_t'(ACC_MAX);
      end else if (sum < ACC_MIN) begin
         return acc_t'(ACC_MIN);
      end
      return acc_t'(sum);
   endfunction

   assign o_init_pop  = (state == IDLE) && !i_init_empty;
   assign take        = (state == TRACK) && i_sample_valid;
   assign o_dump      = (state == WRITE) && !o_wr_req && !i_wr_ack;
   assign o_dump_addr = wr_addr;
   assign o_wr_addr   = wr_addr;
   assign o_wr_data   = {prn_q, acc_e, acc_p, acc_l};

   ca_code_gen u_code_gen (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_load       (o_init_pop),
      .i_prn        (i_init_prn),
      .i_seek_shift (i_init_shift),
      .i_advance    (take),
      .o_chip       (chip),
      .o_seek_done  (seek_done)
   );

   ////////////////////
   // Channel FSM
   ////////////////////

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state    <= IDLE;
         o_wr_req <= 1'b0;
         wr_addr  <= '0;
         smp_cnt  <= '0;
      end else begin
         case (state)
            IDLE: if (o_init_pop) state <= SEEK;
            SEEK: if (seek_done) state <= TRACK;
            TRACK: begin
               if (take) begin
                  smp_cnt <= smp_cnt + 1'b1;
                  if (smp_cnt == ACC_CNT_W'(ACC_LEN - 1)) begin
                     state    <= WRITE;
                     o_wr_req <= 1'b1;
                  end
               end
            end
            WRITE: begin
               if (o_wr_req && i_wr_ack) begin
                  o_wr_req <= 1'b0;
               end else if (o_dump) begin
                  // Wraps at MEM_DEPTH entries.
                  wr_addr <= wr_addr + 1'b1;
                  smp_cnt <= '0;
                  state   <= TRACK;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Early uses the live chip, prompt and late come from history.
   always_ff @(posedge clk) begin
      if (o_init_pop) begin
         prn_q <= i_init_prn;
         hist  <= '0;
         acc_e <= '0;
         acc_p <= '0;
         acc_l <= '0;
      end else if (take) begin
         hist  <= {hist[0], chip};
         acc_e <= sat_acc(acc_e, i_sample, chip);
         acc_p <= sat_acc(acc_p, i_sample, hist[0]);
         acc_l <= sat_acc(acc_l, i_sample, hist[1]);
      end else if (o_dump) begin
         acc_e <= '0;
         acc_p <= '0;
         acc_l <= '0;
      end
   end

endmodule

/* src/gps_track_pkg.sv */
package gps_track_pkg;

   ////////////////////
   // Widths
   ////////////////////

   localparam int SAMPLE_W = 3;
   localparam int PRN_W    = 6;
   localparam int SHIFT_W  = 10;
   localparam int ACC_W    = 8;
   localparam int ADDR_W   = 2;
   localparam int WORD_W   = PRN_W + 3 * ACC_W;

   typedef logic signed [SAMPLE_W-1:0] sample_t;
   typedef logic [PRN_W-1:0]           prn_t;
   typedef logic [SHIFT_W-1:0]         code_shift_t;
   typedef logic signed [ACC_W-1:0]    acc_t;
   typedef logic [ADDR_W-1:0]          mem_addr_t;
   // Entry layout is {prn, early, prompt, late}.
   typedef logic [WORD_W-1:0]          mem_word_t;

   localparam int CA_LEN     = 1023;
   localparam int ACC_LEN    = 16;
   localparam int INIT_DEPTH = 4;
   localparam int MEM_DEPTH  = 4;
   localparam int ACC_CNT_W  = $clog2(ACC_LEN);
   localparam int INIT_PTR_W = $clog2(INIT_DEPTH);
   localparam int ACC_MAX    = 2 ** (ACC_W - 1) - 1;
   localparam int ACC_MIN    = -(2 ** (ACC_W - 1));

   // G2 tap positions per PRN, stages numbered 1 to 10.
   localparam logic [3:0] G2_TAP_A [1:32] = '{
      4'd2, 4'd3, 4'd4, 4'd5, 4'd1, 4'd2, 4'd1, 4'd2, 4'd3, 4'd2, 4'd3,
      4'd5, 4'd6, 4'd7, 4'd8, 4'd9, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6,
      4'd1, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd1, 4'd2, 4'd3, 4'd4};
   localparam logic [3:0] G2_TAP_B [1:32] = '{
      4'd6, 4'd7, 4'd8, 4'd9, 4'd9, 4'd10, 4'd8, 4'd9, 4'd10, 4'd3, 4'd4,
      4'd6, 4'd7, 4'd8, 4'd9, 4'd10, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9,
      4'd3, 4'd6, 4'd7, 4'd8, 4'd9, 4'd10, 4'd6, 4'd7, 4'd8, 4'd9};

   typedef enum logic [1:0] {IDLE, SEEK, TRACK, WRITE} chan_state_e;
   typedef enum logic [1:0] {ARB_IDLE, ARB_SERVE, ARB_RELEASE} arb_state_e;

endpackage

/* src/gps_track_top.sv */
`timescale 1ns/1ps

module gps_track_top (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic                       i_clk_sample,
   input  gps_track_pkg::sample_t     i_data,
   input  logic                       i_acq_valid,
   input  gps_track_pkg::prn_t        i_acq_prn,
   input  gps_track_pkg::code_shift_t i_acq_code_shift,
   output logic                       o_acq_full,
   output logic                       o_trk_valid,
   output gps_track_pkg::prn_t        o_trk_prn,
   output gps_track_pkg::acc_t        o_prompt_mag,
   output logic signed [8:0]          o_code_err
);
   import gps_track_pkg::*;

   sample_t     sample;
   logic        sample_valid;
   logic        init_empty;
   logic        init_pop;
   prn_t        init_prn;
   code_shift_t init_shift;
   logic        wr_req;
   logic        wr_ack;
   mem_addr_t   wr_addr;
   mem_word_t   wr_data;
   logic        rd_req;
   logic        rd_ack;
   mem_addr_t   rd_addr;
   mem_word_t   rd_data;
   logic        dump;
   mem_addr_t   dump_addr;

   ////////////////////
   // Front end
   ////////////////////

   sample_sync u_sample_sync (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_clk_sample   (i_clk_sample),
      .i_data         (i_data),
      .o_sample_valid (sample_valid),
      .o_sample       (sample)
   );

   init_fifo u_init_fifo (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_push  (i_acq_valid),
      .i_prn   (i_acq_prn),
      .i_shift (i_acq_code_shift),
      .i_pop   (init_pop),
      .o_empty (init_empty),
      .o_full  (o_acq_full),
      .o_prn   (init_prn),
      .o_shift (init_shift)
   );

   ////////////////////
   // Channel and memory
   ////////////////////

   correlator_channel u_channel (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_sample_valid (sample_valid),
      .i_sample       (sample),
      .i_init_empty   (init_empty),
      .i_init_prn     (init_prn),
      .i_init_shift   (init_shift),
      .o_init_pop     (init_pop),
      .o_wr_req       (wr_req),
      .o_wr_addr      (wr_addr),
      .o_wr_data      (wr_data),
      .i_wr_ack       (wr_ack),
      .o_dump         (dump),
      .o_dump_addr    (dump_addr)
   );

   track_mem_arbiter u_arbiter (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_wr_req  (wr_req),
      .i_wr_addr (wr_addr),
      .i_wr_data (wr_data),
      .o_wr_ack  (wr_ack),
      .i_rd_req  (rd_req),
      .i_rd_addr (rd_addr),
      .o_rd_ack  (rd_ack),
      .o_rd_data (rd_data)
   );

   code_tracker u_tracker (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_dump       (dump),
      .i_dump_addr  (dump_addr),
      .o_rd_req     (rd_req),
      .o_rd_addr    (rd_addr),
      .i_rd_ack     (rd_ack),
      .i_rd_data    (rd_data),
      .o_trk_valid  (o_trk_valid),
      .o_trk_prn    (o_trk_prn),
      .o_prompt_mag (o_prompt_mag),
      .o_code_err   (o_code_err)
   );

endmodule

/* src/init_fifo.sv */
`timescale 1ns/1ps

module init_fifo (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic                       i_push,
   input  gps_track_pkg::prn_t        i_prn,
   input  gps_track_pkg::code_shift_t i_shift,
   input  logic                       i_pop,
   output logic                       o_empty,
   output logic                       o_full,
   output gps_track_pkg::prn_t        o_prn,
   output gps_track_pkg::code_shift_t o_shift
);
   import gps_track_pkg::*;

   prn_t                  prn_mem   [INIT_DEPTH];
   code_shift_t           shift_mem [INIT_DEPTH];
   logic [INIT_PTR_W-1:0] wr_ptr;
   logic [INIT_PTR_W-1:0] rd_ptr;
   logic [INIT_PTR_W:0]   count;
   logic                  do_push;
   logic                  do_pop;

   assign o_empty = (count == '0);
   assign o_full  = (count == (INIT_PTR_W + 1)'(INIT_DEPTH));
   assign do_push = i_push && !o_full;
   assign do_pop  = i_pop && !o_empty;

   // Head of queue.
   assign o_prn   = prn_mem[rd_ptr];
   assign o_shift = shift_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + do_push - do_pop;
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         prn_mem[wr_ptr]   <= i_prn;
         shift_mem[wr_ptr] <= i_shift;
      end
   end

endmodule

/* src/sample_sync.sv */
`timescale 1ns/1ps

module sample_sync (
   input  logic                   clk,
   input  logic                   i_rst_n,
   input  logic                   i_clk_sample,
   input  gps_track_pkg::sample_t i_data,
   output logic                   o_sample_valid,
   output gps_track_pkg::sample_t o_sample
);
   import gps_track_pkg::*;

   // Two synchronizer stages plus one stage of edge history.
   logic [2:0] clk_sync;
   logic       edge_det;
   logic [1:0] hold_dly;

   assign edge_det = clk_sync[1] & ~clk_sync[2];

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         clk_sync       <= '0;
         hold_dly       <= '0;
         o_sample_valid <= 1'b0;
      end else begin
         clk_sync       <= {clk_sync[1:0], i_clk_sample};
         hold_dly       <= {hold_dly[0], edge_det};
         o_sample_valid <= hold_dly[1];
      end
   end

   // Data bits are stable by the time the delayed strobe fires.
   always_ff @(posedge clk) begin
      if (hold_dly[1]) begin
         o_sample <= i_data;
      end
   end

endmodule

/* src/track_mem_arbiter.sv */
`timescale 1ns/1ps

module track_mem_arbiter (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  logic                     i_wr_req,
   input  gps_track_pkg::mem_addr_t i_wr_addr,
   input  gps_track_pkg::mem_word_t i_wr_data,
   output logic                     o_wr_ack,
   input  logic                     i_rd_req,
   input  gps_track_pkg::mem_addr_t i_rd_addr,
   output logic                     o_rd_ack,
   output gps_track_pkg::mem_word_t o_rd_data
);
   import gps_track_pkg::*;

   arb_state_e state;
   mem_word_t  mem [MEM_DEPTH];
   logic       sel_rd;   // Granted client, 1 for the reader.
   logic       last_rd;
   logic       pick_rd;
   logic       sel_req;

   // On a tie the client that lost last time wins.
   assign pick_rd = i_rd_req && (!i_wr_req || !last_rd);
   assign sel_req = sel_rd ? i_rd_req : i_wr_req;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state    <= ARB_IDLE;
         sel_rd   <= 1'b0;
         last_rd  <= 1'b0;
         o_wr_ack <= 1'b0;
         o_rd_ack <= 1'b0;
      end else begin
         case (state)
            ARB_IDLE: begin
               if (i_wr_req || i_rd_req) begin
                  sel_rd  <= pick_rd;
                  last_rd <= pick_rd;
                  state   <= ARB_SERVE;
               end
            end
            ARB_SERVE: begin
               o_rd_ack <= sel_rd;
               o_wr_ack <= !sel_rd;
               state    <= ARB_RELEASE;
            end
            ARB_RELEASE: begin
               if (!sel_req) begin
                  o_rd_ack <= 1'b0;
                  o_wr_ack <= 1'b0;
                  state    <= ARB_IDLE;
               end
            end
            default: state <= ARB_IDLE;
         endcase
      end
   end

   ////////////////////
   // Results memory
   ////////////////////

   always_ff @(posedge clk) begin
      if (state == ARB_SERVE) begin
         if (sel_rd) begin
            o_rd_data <= mem[i_rd_addr];
         end else begin
            mem[i_wr_addr] <= i_wr_data;
         end
      end
   end

endmodule

/* vlog.f */
src/gps_track_pkg.sv
src/sample_sync.sv
src/init_fifo.sv
src/ca_code_gen.sv
src/correlator_channel.sv
src/track_mem_arbiter.sv
src/code_tracker.sv
src/gps_track_top.sv
sim/tb_gps_track.sv
